// ==== tb.f ====
hw/uart_timing_pkg.sv
hw/uart_frame_pkg.sv
hw/uart_rx_if.sv
hw/uart_baud_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart.sv
hw/uart_top.sv
tb/tb_uart_top.sv

// ==== Bender.yml ====
package:
  name: uart_top

sources:
  - hw/uart_timing_pkg.sv
  - hw/uart_frame_pkg.sv
  - hw/uart_rx_if.sv
  - hw/uart_baud_gen.sv
  - hw/uart_tx.sv
  - hw/uart_rx.sv
  - hw/uart.sv
  - hw/uart_top.sv
  - target: test
    files:
      - tb/tb_uart_top.sv

// ==== tb/tb_uart_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Line models assume a 64 clk bit time. Checks sample on the rising edge
// and so see DUT outputs one cycle after the edge that sets them
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_uart_top;
    import uart_timing_pkg::*;
    import uart_frame_pkg::*;

    localparam int BIT_CLKS    = CLKS_PER_SAMPLE * OVERSAMPLE;
    localparam int FRAME_CLKS  = FRAME_BITS * BIT_CLKS;
    localparam int CLK_PERIOD  = 20;
    localparam int TX_FRAMES   = 20;
    localparam int LOOP_FRAMES = 10;
    localparam int ERR_FRAMES  = 4;
    // Idle waits of the glitch and ignored-write tests in frames
    localparam int IDLE_FRAMES = 5;
    localparam int ALL_FRAMES  = TX_FRAMES + LOOP_FRAMES + 2 * ERR_FRAMES + IDLE_FRAMES;
    localparam int LIMIT_NS    = ALL_FRAMES * FRAME_CLKS * CLK_PERIOD * 2;

    logic       clk;
    logic       reset_b;
    data_word_t tx_data;
    logic       tx_write;
    logic       rx_in;
    logic       tx_out;
    logic       tx_ready;
    data_word_t rx_data;
    logic       rx_ready;
    logic       rx_frame_error;
    logic       rx_parity_error;

    // Line model state
    logic       loopback;
    logic       drv_line;
    logic       reset_check;

    // Expected receive results as {frame_error, parity_error, data}
    logic [DATA_BITS+1:0] exp_q[$];
    logic [DATA_BITS+1:0] exp_word;

    integer seed;
    int     errors;
    int     rx_count;
    int     test_errors;
    int     tests_run;
    int     tests_bad;

    uart_top dut_i (
        .clk             (clk),
        .reset_b         (reset_b),
        .tx_data         (tx_data),
        .tx_write        (tx_write),
        .rx_in           (rx_in),
        .tx_out          (tx_out),
        .tx_ready        (tx_ready),
        .rx_data         (rx_data),
        .rx_ready        (rx_ready),
        .rx_frame_error  (rx_frame_error),
        .rx_parity_error (rx_parity_error)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Receiver input looped from the transmitter or from the driver
    assign rx_in = loopback ? tx_out : drv_line;

    // Line level of frame bit b
    // Start, data LSB first, even parity, then stop
    function automatic logic frame_bit(input data_word_t w, input int b);
        logic bit_v;
        if (b == 0) begin
            bit_v = 1'b0;
        end else if (b <= DATA_BITS) begin
            bit_v = w[b-1];
        end else if (b == DATA_BITS + 1) begin
            bit_v = ^w;
        end else begin
            bit_v = 1'b1;
        end
        return bit_v;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Output checkers
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        // Idle values during and just after reset
        if (reset_check) begin
            assert (tx_out === 1'b1 && tx_ready === 1'b1 && rx_ready === 1'b0 &&
                    rx_data === '1 && rx_frame_error === 1'b0 &&
                    rx_parity_error === 1'b0) else begin
                $display("[ERROR] %0t: reset state tx_out %b tx_ready %b rx_ready %b rx_data %h",
                         $time, tx_out, tx_ready, rx_ready, rx_data);
                errors++;
            end
        end
        // Every strobe takes the oldest expected word
        if (reset_b === 1'b1 && rx_ready === 1'b1) begin
            rx_count++;
            if (exp_q.size() == 0) begin
                $display("%0t: rx_ready strobe with %h when no frame was sent", $time, rx_data);
                errors++;
            end else begin
                exp_word = exp_q.pop_front();
                assert (rx_data === exp_word[DATA_BITS-1:0]) else begin
                    $display("[ERROR] %0t: rx_data %h, expected %h",
                             $time, rx_data, exp_word[DATA_BITS-1:0]);
                    errors++;
                end
                assert (rx_frame_error === exp_word[DATA_BITS+1] &&
                        rx_parity_error === exp_word[DATA_BITS]) else begin
                    $display("[ERROR] %0t: flags frame %b parity %b, expected %b %b", $time,
                             rx_frame_error, rx_parity_error,
                             exp_word[DATA_BITS+1], exp_word[DATA_BITS]);
                    errors++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and line models
    ////////////////////////////////////////////////////////////////////////////

    // Write once tx_ready is seen high and expect it low afterwards
    task automatic write_word(input data_word_t w);
        int n;
        n = 0;
        while (tx_ready !== 1'b1 && n < 2 * FRAME_CLKS) begin
            @(posedge clk);
            n++;
        end
        tx_data  <= w;
        tx_write <= 1'b1;
        @(posedge clk);
        tx_write <= 1'b0;
        @(posedge clk);
        assert (tx_ready === 1'b0) else begin
            $display("[ERROR] %0t: tx_ready still high after write of %h", $time, w);
            errors++;
        end
    endtask

    // Bounded by two frames
    task automatic wait_tx_idle();
        int n;
        n = 0;
        while (tx_ready !== 1'b1 && n < 2 * FRAME_CLKS) begin
            @(posedge clk);
            n++;
        end
        if (tx_ready !== 1'b1) begin
            $display("%0t: transmitter stayed busy, tx_ready never returned high", $time);
            errors++;
        end
    endtask

    // Every cycle of every tx_out bit must hold the expected level
    task automatic check_tx_frame(input data_word_t w);
        int n;
        int b;
        int c;
        logic exp_bit;
        n = 0;
        while (tx_out !== 1'b0 && n < 2 * BIT_CLKS) begin
            @(posedge clk);
            n++;
        end
        if (tx_out !== 1'b0) begin
            $display("%0t: transmitter never sent a start bit for %h", $time, w);
            errors++;
        end else begin
            for (b = 0; b < FRAME_BITS; b++) begin
                exp_bit = frame_bit(w, b);
                for (c = 0; c < BIT_CLKS; c++) begin
                    if (b != 0 || c != 0) begin
                        @(posedge clk);
                    end
                    assert (tx_out === exp_bit && tx_ready === 1'b0) else begin
                        $display("[ERROR] %0t: %h bit %0d tx_out %b tx_ready %b, expected %b 0",
                                 $time, w, b, tx_out, tx_ready, exp_bit);
                        errors++;
                    end
                end
            end
        end
    endtask

    // Drive one frame on rx_in with optional faults and two idle bits after it
    task automatic drive_frame(input data_word_t w, input logic bad_parity, input logic bad_stop);
        int b;
        logic bit_v;
        exp_q.push_back({bad_stop, bad_parity, w});
        for (b = 0; b < FRAME_BITS; b++) begin
            bit_v = frame_bit(w, b);
            if (b == DATA_BITS + 1 && bad_parity) begin
                bit_v = ~bit_v;
            end
            if (b == DATA_BITS + 2 && bad_stop) begin
                bit_v = 1'b0;
            end
            drv_line <= bit_v;
            repeat (BIT_CLKS) @(posedge clk);
        end
        drv_line <= 1'b1;
        repeat (2 * BIT_CLKS) @(posedge clk);
    endtask

    // Wait until every sent word has come back
    task automatic wait_rx_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 2 * FRAME_CLKS) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%0t: receiver never delivered %0d sent words", $time, exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic start_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - test_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        data_word_t w;
        int         count_before;
        int         i;
        clk         = 1'b0;
        reset_b     = 1'b0;
        tx_data     = '0;
        tx_write    = 1'b0;
        loopback    = 1'b0;
        drv_line    = 1'b1;
        reset_check = 1'b0;
        seed        = 14419;
        errors      = 0;
        rx_count    = 0;
        tests_run   = 0;
        tests_bad   = 0;

        // Reset state checked from the second edge on
        start_test();
        @(posedge clk);
        reset_check <= 1'b1;
        repeat (4) @(posedge clk);
        reset_b <= 1'b1;
        repeat (8) @(posedge clk);
        reset_check <= 1'b0;
        end_test("reset_state");

        // Transmit framing with the receiver line held idle
        start_test();
        for (i = 0; i < TX_FRAMES; i++) begin
            w = data_word_t'($random(seed));
            write_word(w);
            check_tx_frame(w);
        end
        wait_tx_idle();
        end_test("tx_framing");

        // Loopback returns words in send order
        start_test();
        loopback <= 1'b1;
        @(posedge clk);
        for (i = 0; i < LOOP_FRAMES; i++) begin
            w = data_word_t'($random(seed));
            exp_q.push_back({2'b00, w});
            write_word(w);
            wait_tx_idle();
        end
        wait_rx_drain();
        loopback <= 1'b0;
        @(posedge clk);
        end_test("loopback");

        // Wrong parity first and a low stop bit after
        start_test();
        for (i = 0; i < ERR_FRAMES; i++) begin
            drive_frame(data_word_t'($random(seed)), 1'b1, 1'b0);
        end
        for (i = 0; i < ERR_FRAMES; i++) begin
            drive_frame(data_word_t'($random(seed)), 1'b0, 1'b1);
        end
        wait_rx_drain();
        end_test("error_detect");

        // Low pulse of 3 samples on rx_in
        start_test();
        count_before = rx_count;
        drv_line <= 1'b0;
        repeat (3 * CLKS_PER_SAMPLE) @(posedge clk);
        drv_line <= 1'b1;
        repeat (2 * FRAME_CLKS) @(posedge clk);
        assert (rx_count == count_before) else begin
            $display("%0t: receiver took a 3-sample glitch as a frame", $time);
            errors++;
        end
        end_test("glitch_reject");

        // Second write lands mid-frame and must be dropped
        start_test();
        w = data_word_t'($random(seed));
        write_word(w);
        fork
            check_tx_frame(w);
            begin
                repeat (3 * BIT_CLKS) @(posedge clk);
                tx_data  <= ~w;
                tx_write <= 1'b1;
                @(posedge clk);
                tx_write <= 1'b0;
            end
        join
        repeat (2 * FRAME_CLKS) begin
            @(posedge clk);
            assert (tx_out === 1'b1 && tx_ready === 1'b1) else begin
                $display("[ERROR] %0t: extra frame after busy write, tx_out %b tx_ready %b",
                         $time, tx_out, tx_ready);
                errors++;
            end
        end
        end_test("ignored_write");

        $display("%0d tests run, %0d ok, %0d failing, %0d errors",
                 tests_run, tests_run - tests_bad, tests_bad, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog allows twice the time of every frame and idle wait
    initial begin
        #(LIMIT_NS);
        $display("Run timed out after %0d ns without finishing the tests", LIMIT_NS);
        $display("test failed");
        $finish;
    end

endmodule

// ==== hw/uart_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Baud rate fixed by uart_timing_pkg, bit time is 64 clk
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_top (
    input  logic                                 clk,
    input  logic                                 reset_b,
    input  logic [uart_frame_pkg::DATA_BITS-1:0] tx_data,
    input  logic                                 tx_write,
    input  logic                                 rx_in,
    output logic                                 tx_out,
    output logic                                 tx_ready,
    output logic [uart_frame_pkg::DATA_BITS-1:0] rx_data,
    output logic                                 rx_ready,
    output logic                                 rx_frame_error,
    output logic                                 rx_parity_error
);

    // Enable ticks shared by both serial engines
    logic sample_tick;
    logic bit_tick;

    uart_baud_gen baud_i (
        .clk         (clk),
        .reset_b     (reset_b),
        .sample_tick (sample_tick),
        .bit_tick    (bit_tick)
    );

    uart uart_i (
        .clk             (clk),
        .reset_b         (reset_b),
        .sample_tick     (sample_tick),
        .bit_tick        (bit_tick),
        .tx_data         (tx_data),
        .tx_write        (tx_write),
        .rx_in           (rx_in),
        .tx_out          (tx_out),
        .tx_ready        (tx_ready),
        .rx_data         (rx_data),
        .rx_ready        (rx_ready),
        .rx_frame_error  (rx_frame_error),
        .rx_parity_error (rx_parity_error)
    );

endmodule

// ==== hw/uart.sv ====
////////////////////////////////////////////////////////////////////////////
// No receive buffering. Each new word overwrites the last one
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart (
    input  logic                       clk,
    input  logic                       reset_b,
    input  logic                       sample_tick,
    input  logic                       bit_tick,
    input  uart_frame_pkg::data_word_t tx_data,
    input  logic                       tx_write,
    input  logic                       rx_in,
    output logic                       tx_out,
    output logic                       tx_ready,
    output uart_frame_pkg::data_word_t rx_data,
    output logic                       rx_ready,
    output logic                       rx_frame_error,
    output logic                       rx_parity_error
);

    // Receiver result
    uart_rx_if rx_if ();

    uart_tx tx_i (
        .clk      (clk),
        .reset_b  (reset_b),
        .bit_tick (bit_tick),
        .tx_data  (tx_data),
        .tx_write (tx_write),
        .tx_ready (tx_ready),
        .tx_out   (tx_out)
    );

    uart_rx rx_i (
        .clk         (clk),
        .reset_b     (reset_b),
        .sample_tick (sample_tick),
        .rx_in       (rx_in),
        .rx_bus      (rx_if.source)
    );

    // Received word register, all ones until the first frame
    // Strobe delayed one cycle to line up with the registered word
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rx_data         <= '1;
            rx_ready        <= 1'b0;
            rx_frame_error  <= 1'b0;
            rx_parity_error <= 1'b0;
        end else begin
            rx_ready <= rx_if.valid;
            if (rx_if.valid) begin
                rx_data         <= rx_if.data;
                rx_frame_error  <= rx_if.frame_error;
                rx_parity_error <= rx_if.parity_error;
            end
        end
    end

endmodule

// ==== hw/uart_rx.sv ====
////////////////////////////////////////////////////////////////////////////
// Start pulses shorter than half a bit are dropped. A new frame needs a
// falling edge, so a line stuck low after a frame error stays silent
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_rx (
    input  logic      clk,
    input  logic      reset_b,
    input  logic      sample_tick,
    input  logic      rx_in,
    uart_rx_if.source rx_bus
);
    import uart_timing_pkg::*;
    import uart_frame_pkg::*;

    logic                    rx_meta;
    logic                    rx_sync;
    logic                    rx_prev;
    logic                    start_edge;
    logic                    mid_bit;
    rx_state_t               state;
    logic [SAMPLE_CNT_W-1:0] sample_cnt;
    logic [BIT_CNT_W-1:0]    bit_cnt;
    data_word_t              shift_q;
    logic                    parity_q;
    logic                    valid_q;
    logic                    frame_err_q;
    logic                    parity_err_q;

    ////////////////////////////////////////////////////////////////////////////
    // Input synchronizer and edge detect
    ////////////////////////////////////////////////////////////////////////////

    // Two flops, then one more for the edge, all idle high
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_in;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev && !rx_sync;

    // Centre of the current bit
    // Counter wraps once per bit so this repeats every OVERSAMPLE ticks
    assign mid_bit = sample_tick && (sample_cnt == SAMPLE_CNT_W'(MID_SAMPLE));

    // Sample counter, phase locked to the start edge
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            sample_cnt <= '0;
        end else if ((state == RX_IDLE) && start_edge) begin
            sample_cnt <= '0;
        end else if (sample_tick) begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    // Data bits arrive LSB first, shift in at the top
    always_ff @(posedge clk) begin
        if (mid_bit && (state == RX_DATA)) begin
            shift_q <= {rx_sync, shift_q[DATA_BITS-1:1]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state        <= RX_IDLE;
            bit_cnt      <= '0;
            parity_q     <= 1'b0;
            valid_q      <= 1'b0;
            frame_err_q  <= 1'b0;
            parity_err_q <= 1'b0;
        end else begin
            // Strobe lasts one cycle
            valid_q <= 1'b0;
            unique case (state)
                RX_IDLE: begin
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (mid_bit) begin
                        if (rx_sync) begin
                            // Glitch, line back high by half a bit
                            state <= RX_IDLE;
                        end else begin
                            bit_cnt  <= '0;
                            parity_q <= 1'b0;
                            state    <= RX_DATA;
                        end
                    end
                end
                RX_DATA: begin
                    if (mid_bit) begin
                        parity_q <= parity_q ^ rx_sync;
                        if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1)) begin
                            state <= RX_PARITY;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                RX_PARITY: begin
                    // Even parity leaves the running XOR at zero
                    if (mid_bit) begin
                        parity_q <= parity_q ^ rx_sync;
                        state    <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (mid_bit) begin
                        valid_q      <= 1'b1;
                        frame_err_q  <= !rx_sync;
                        parity_err_q <= parity_q;
                        state        <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // Result to the wrapper
    assign rx_bus.data         = shift_q;
    assign rx_bus.valid        = valid_q;
    assign rx_bus.frame_error  = frame_err_q;
    assign rx_bus.parity_error = parity_err_q;

endmodule

// ==== hw/uart_tx.sv ====
////////////////////////////////////////////////////////////////////////////
// Writes while busy are dropped. Start bit waits for the next bit tick,
// so latency from write to start varies by up to one bit time
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_tx (
    input  logic                       clk,
    input  logic                       reset_b,
    input  logic                       bit_tick,
    input  uart_frame_pkg::data_word_t tx_data,
    input  logic                       tx_write,
    output logic                       tx_ready,
    output logic                       tx_out
);
    import uart_frame_pkg::*;

    tx_state_t            state;
    data_word_t           shift_q;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic                 parity_q;
    logic                 load;
    logic                 last_data;
    logic                 shift_en;

    // tx_ready is only high in idle
    assign load = tx_write && tx_ready;

    // Last data bit is on the line
    assign last_data = (bit_cnt == BIT_CNT_W'(DATA_BITS - 1));

    // Next data bit leaves the register
    assign shift_en = bit_tick &&
                      ((state == TX_START) || ((state == TX_DATA) && !last_data));

    ////////////////////////////////////////////////////////////////////////////
    // Data shift register
    ////////////////////////////////////////////////////////////////////////////

    // LSB goes out first, zeros fill from the top
    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= tx_data;
        end else if (shift_en) begin
            shift_q <= {1'b0, shift_q[DATA_BITS-1:1]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////////////////////

    // Line driven from a register so it never glitches
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state    <= TX_IDLE;
            bit_cnt  <= '0;
            parity_q <= 1'b0;
            tx_ready <= 1'b1;
            tx_out   <= 1'b1;
        end else begin
            unique case (state)
                TX_IDLE: begin
                    if (load) begin
                        // Word held, wait for bit boundary
                        tx_ready <= 1'b0;
                        bit_cnt  <= '0;
                        parity_q <= 1'b0;
                    end else if (bit_tick && !tx_ready) begin
                        tx_out <= 1'b0;
                        state  <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_tick) begin
                        // Bit 0 out
                        tx_out   <= shift_q[0];
                        parity_q <= parity_q ^ shift_q[0];
                        state    <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_tick) begin
                        if (last_data) begin
                            // Even parity, accumulated over all data bits
                            tx_out <= parity_q;
                            state  <= TX_PARITY;
                        end else begin
                            tx_out   <= shift_q[0];
                            parity_q <= parity_q ^ shift_q[0];
                            bit_cnt  <= bit_cnt + 1'b1;
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_tick) begin
                        tx_out <= 1'b1;
                        state  <= TX_STOP;
                    end
                end
                TX_STOP: begin
                    // Ready again on the tick ending the stop bit
                    if (bit_tick) begin
                        tx_ready <= 1'b1;
                        state    <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hw/uart_baud_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Free running from reset, first sample_tick CLKS_PER_SAMPLE cycles later
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_baud_gen (
    input  logic clk,
    input  logic reset_b,
    output logic sample_tick,
    output logic bit_tick
);
    import uart_timing_pkg::*;

    logic [CLK_CNT_W-1:0]    clk_cnt;
    logic [SAMPLE_CNT_W-1:0] sample_cnt;
    logic                    clk_wrap;
    logic                    sample_wrap;

    // Last cycle of a sample period
    assign clk_wrap = (clk_cnt == CLK_CNT_W'(CLKS_PER_SAMPLE - 1));
    // Last sample of a bit period
    assign sample_wrap = (sample_cnt == SAMPLE_CNT_W'(OVERSAMPLE - 1));

    // Both counters, sample count advances once per sample period
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            clk_cnt    <= '0;
            sample_cnt <= '0;
        end else begin
            if (clk_wrap) begin
                clk_cnt <= '0;
                if (sample_wrap) begin
                    sample_cnt <= '0;
                end else begin
                    sample_cnt <= sample_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // Registered ticks
    // bit_tick coincides with every OVERSAMPLE-th sample_tick
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            sample_tick <= 1'b0;
            bit_tick    <= 1'b0;
        end else begin
            sample_tick <= clk_wrap;
            bit_tick    <= clk_wrap && sample_wrap;
        end
    end

endmodule

// ==== hw/uart_rx_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Data and error flags are only meaningful while valid is high
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface uart_rx_if;
    import uart_frame_pkg::*;

    // Received word
    data_word_t data;
    // One-cycle strobe per frame
    logic       valid;
    // Stop bit sampled low
    logic       frame_error;
    // Odd count of ones over data and parity
    logic       parity_error;

    // Receiver side
    modport source (output data, output valid, output frame_error, output parity_error);

    // Consumer side
    modport sink (input data, input valid, input frame_error, input parity_error);

endinterface

// ==== hw/uart_frame_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Frame is fixed at 8 data bits, even parity, one stop bit, idle high
////////////////////////////////////////////////////////////////////////////

package uart_frame_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Frame format
    ////////////////////////////////////////////////////////////////////////////

    // Data bits per frame, sent LSB first
    localparam int unsigned DATA_BITS = 8;

    // Data bit counter width
    localparam int unsigned BIT_CNT_W = 3;

    // Start + data + parity + stop
    localparam int unsigned FRAME_BITS = DATA_BITS + 3;

    // One data word
    typedef logic [DATA_BITS-1:0] data_word_t;

    ////////////////////////////////////////////////////////////////////////////
    // Serial engine states
    ////////////////////////////////////////////////////////////////////////////

    // Transmitter, state names the bit currently on the line
    // IDLE also covers the wait for the first bit tick after a write
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_t;

    // Receiver, state names the bit expected at the next centre sample
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

endpackage

// ==== hw/uart_timing_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Rates are fixed at elaboration. OVERSAMPLE must equal 2**SAMPLE_CNT_W
// because the receiver lets its sample counter wrap between bit centres
////////////////////////////////////////////////////////////////////////////

package uart_timing_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Divider
    ////////////////////////////////////////////////////////////////////////////

    // clk cycles per oversample tick
    // Kept small so a frame is short in simulation
    localparam int unsigned CLKS_PER_SAMPLE = 4;

    // Width of the clk cycle counter in the baud generator
    localparam int unsigned CLK_CNT_W = $clog2(CLKS_PER_SAMPLE);

    ////////////////////////////////////////////////////////////////////////////
    // Oversampling
    ////////////////////////////////////////////////////////////////////////////

    // Samples per bit
    localparam int unsigned OVERSAMPLE = 16;

    // Sample counter width, one full bit per wrap
    localparam int unsigned SAMPLE_CNT_W = 4;

    // Sample index nearest the bit centre
    // Counted from the start edge, so this is the 8th sample
    localparam int unsigned MID_SAMPLE = OVERSAMPLE / 2 - 1;

endpackage
